// ==== logic/gem_stream_pkg.sv ====
package gem_stream_pkg;

    // bus widths
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 13;
    localparam int ID_WIDTH = 4;

    // two 4 KB pages, selected by the top address bit
    localparam int PAGE_BIT = 12;
    localparam int PAGE_ADDR_WIDTH = 12;

    // full-width INCR bursts only
    localparam int BYTES_PER_BEAT = DATA_WIDTH / 8;

    localparam logic DATA_PAGE = 1'b0;
    localparam logic CONTROL_PAGE = 1'b1;

    // a data write landing here starts a new packet
    localparam logic [PAGE_ADDR_WIDTH-1:0] DATA_BASE_ADDR = 12'h000;

    // register 0 of the control page, written by the driver on the DMA interrupt
    localparam logic [PAGE_ADDR_WIDTH-1:0] DMA_COMPLETE_REG = 12'h000;
    localparam logic [DATA_WIDTH-1:0] DMA_COMPLETE_MASK = 32'h0000_0001;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // entries in each of the joiner FIFOs
    localparam int JOIN_DEPTH = 4;

    // write controller FSM
    typedef enum logic [1:0] {
        ST_ADDR,
        ST_DATA,
        ST_RESP
    } write_state_t;

endpackage

// ==== logic/axi_write_ctrl.sv ====
`timescale 1ns/1ps

module axi_write_ctrl (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic [gem_stream_pkg::ID_WIDTH-1:0]   i_awid,
    input  logic [gem_stream_pkg::ADDR_WIDTH-1:0] i_awaddr,
    input  logic [7:0]                            i_awlen,
    input  logic                                  i_awvalid,
    input  logic [gem_stream_pkg::DATA_WIDTH-1:0] i_wdata,
    input  logic                                  i_wlast,
    input  logic                                  i_wvalid,
    input  logic                                  i_bready,
    input  logic                                  i_join_wready,

    output logic                                  o_awready,
    output logic                                  o_wready,
    output logic [gem_stream_pkg::ID_WIDTH-1:0]   o_bid,
    output logic                                  o_bvalid,
    output logic                                  o_join_wvalid,
    output logic [gem_stream_pkg::DATA_WIDTH-1:0] o_join_wdata,
    output logic                                  o_beat_valid,
    output logic                                  o_beat_at_base,
    output logic                                  o_dma_complete
);

    gem_stream_pkg::write_state_t state;

    // burst context captured from AW
    logic                                       r_page;
    logic [gem_stream_pkg::PAGE_ADDR_WIDTH-1:0] r_page_addr;
    logic [gem_stream_pkg::ID_WIDTH-1:0]        r_id;
    logic [7:0]                                 r_beats_left;

    logic aw_fire;
    logic w_fire;
    logic burst_done;
    logic is_data_page;
    logic dma_hit;

    assign is_data_page = (r_page == gem_stream_pkg::DATA_PAGE);

    assign o_awready = (state == gem_stream_pkg::ST_ADDR);
    assign o_bvalid = (state == gem_stream_pkg::ST_RESP);
    assign o_bid = r_id;

    // control writes never stall, data writes wait for room in the joiner
    assign o_wready = (state == gem_stream_pkg::ST_DATA) && (!is_data_page || i_join_wready);

    assign o_join_wvalid = (state == gem_stream_pkg::ST_DATA) && i_wvalid && is_data_page;
    assign o_join_wdata = i_wdata;

    assign aw_fire = i_awvalid && o_awready;
    assign w_fire = i_wvalid && o_wready;

    // wlast normally ends the burst, the length count covers a missing wlast
    assign burst_done = w_fire && (i_wlast || r_beats_left == 8'd0);

    assign dma_hit = (r_page == gem_stream_pkg::CONTROL_PAGE)
                  && (r_page_addr == gem_stream_pkg::DMA_COMPLETE_REG)
                  && |(i_wdata & gem_stream_pkg::DMA_COMPLETE_MASK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= gem_stream_pkg::ST_ADDR;
        end else begin
            case (state)
                gem_stream_pkg::ST_ADDR: begin
                    if (aw_fire) begin
                        state <= gem_stream_pkg::ST_DATA;
                    end
                end
                gem_stream_pkg::ST_DATA: begin
                    if (burst_done) begin
                        state <= gem_stream_pkg::ST_RESP;
                    end
                end
                gem_stream_pkg::ST_RESP: begin
                    if (i_bready) begin
                        state <= gem_stream_pkg::ST_ADDR;
                    end
                end
                default: begin
                    state <= gem_stream_pkg::ST_ADDR;
                end
            endcase
        end
    end

    // beat address follows the accepted W beats, so it always matches the data
    always_ff @(posedge clk) begin
        if (aw_fire) begin
            r_page <= i_awaddr[gem_stream_pkg::PAGE_BIT];
            r_page_addr <= i_awaddr[gem_stream_pkg::PAGE_ADDR_WIDTH-1:0];
            r_id <= i_awid;
            r_beats_left <= i_awlen;
        end else if (w_fire) begin
            r_page_addr <= r_page_addr
                         + gem_stream_pkg::PAGE_ADDR_WIDTH'(gem_stream_pkg::BYTES_PER_BEAT);
            r_beats_left <= r_beats_left - 8'd1;
        end
    end

    // event pulses, one cycle after the W beat
    always_ff @(posedge clk) begin
        if (reset) begin
            o_beat_valid <= 1'b0;
            o_dma_complete <= 1'b0;
        end else begin
            o_beat_valid <= w_fire && is_data_page;
            o_dma_complete <= w_fire && dma_hit;
        end
    end

    always_ff @(posedge clk) begin
        o_beat_at_base <= (r_page_addr == gem_stream_pkg::DATA_BASE_ADDR);
    end

endmodule

// ==== logic/beat_last_tracker.sv ====
`timescale 1ns/1ps

module beat_last_tracker (
    input  logic clk,
    input  logic reset,

    input  logic i_beat_valid,
    input  logic i_beat_at_base,
    input  logic i_dma_complete,

    output logic o_flag_valid,
    output logic o_flag_last
);

    // one data beat whose tlast is still open
    logic r_pending;

    always_ff @(posedge clk) begin
        if (reset) begin
            r_pending <= 1'b0;
            o_flag_valid <= 1'b0;
        end else begin
            o_flag_valid <= 1'b0;
            if (i_beat_valid) begin
                // the new beat decides the previous one and takes its place
                o_flag_valid <= r_pending;
                r_pending <= 1'b1;
            end else if (i_dma_complete && r_pending) begin
                o_flag_valid <= 1'b1;
                r_pending <= 1'b0;
            end
        end
    end

    // a write back to the base address means the pending beat closed its packet
    always_ff @(posedge clk) begin
        if (i_beat_valid) begin
            o_flag_last <= i_beat_at_base;
        end else if (i_dma_complete) begin
            o_flag_last <= 1'b1;
        end
    end

endmodule

// ==== logic/beat_join.sv ====
`timescale 1ns/1ps

module beat_join (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic                                  i_wvalid,
    input  logic [gem_stream_pkg::DATA_WIDTH-1:0] i_wdata,
    input  logic                                  i_flag_valid,
    input  logic                                  i_flag_last,
    input  logic                                  i_tready,

    output logic                                  o_wready,
    output logic [gem_stream_pkg::DATA_WIDTH-1:0] o_tdata,
    output logic                                  o_tlast,
    output logic                                  o_tvalid
);

    localparam int PTR_W = $clog2(gem_stream_pkg::JOIN_DEPTH);
    localparam int CNT_W = $clog2(gem_stream_pkg::JOIN_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(gem_stream_pkg::JOIN_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(gem_stream_pkg::JOIN_DEPTH);

    logic [gem_stream_pkg::DATA_WIDTH-1:0] d_mem [gem_stream_pkg::JOIN_DEPTH];
    logic [PTR_W-1:0] d_wr_ptr;
    logic [PTR_W-1:0] d_rd_ptr;
    logic [CNT_W-1:0] d_count;

    logic             f_mem [gem_stream_pkg::JOIN_DEPTH];
    logic [PTR_W-1:0] f_wr_ptr;
    logic [PTR_W-1:0] f_rd_ptr;
    logic [CNT_W-1:0] f_count;

    logic d_push;
    logic f_push;
    logic pop;

    // wrap at the FIFO depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign o_wready = (d_count != FULL_CNT);
    assign d_push = i_wvalid && o_wready;
    // flags trail the data, so the flag FIFO has room whenever a flag arrives
    assign f_push = i_flag_valid;

    // a stream beat needs both its data and its decided flag
    assign o_tvalid = (d_count != '0) && (f_count != '0);
    assign o_tdata = d_mem[d_rd_ptr];
    assign o_tlast = f_mem[f_rd_ptr];
    assign pop = o_tvalid && i_tready;

    always_ff @(posedge clk) begin
        if (d_push) begin
            d_mem[d_wr_ptr] <= i_wdata;
        end
        if (f_push) begin
            f_mem[f_wr_ptr] <= i_flag_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            d_wr_ptr <= '0;
            d_rd_ptr <= '0;
            d_count <= '0;
            f_wr_ptr <= '0;
            f_rd_ptr <= '0;
            f_count <= '0;
        end else begin
            if (d_push) d_wr_ptr <= next_ptr(d_wr_ptr);
            if (f_push) f_wr_ptr <= next_ptr(f_wr_ptr);
            if (pop) begin
                d_rd_ptr <= next_ptr(d_rd_ptr);
                f_rd_ptr <= next_ptr(f_rd_ptr);
            end
            d_count <= d_count + CNT_W'(d_push) - CNT_W'(pop);
            f_count <= f_count + CNT_W'(f_push) - CNT_W'(pop);
        end
    end

endmodule

// ==== logic/gem_write_to_stream.sv ====
`timescale 1ns/1ps

module gem_write_to_stream (
    input  logic                                  clk,
    input  logic                                  reset,

    input  logic [gem_stream_pkg::ID_WIDTH-1:0]   i_awid,
    input  logic [gem_stream_pkg::ADDR_WIDTH-1:0] i_awaddr,
    input  logic [7:0]                            i_awlen,
    input  logic                                  i_awvalid,
    output logic                                  o_awready,

    input  logic [gem_stream_pkg::DATA_WIDTH-1:0] i_wdata,
    input  logic                                  i_wlast,
    input  logic                                  i_wvalid,
    output logic                                  o_wready,

    output logic [gem_stream_pkg::ID_WIDTH-1:0]   o_bid,
    output logic [1:0]                            o_bresp,
    output logic                                  o_bvalid,
    input  logic                                  i_bready,

    output logic [gem_stream_pkg::DATA_WIDTH-1:0] o_tdata,
    output logic                                  o_tlast,
    output logic                                  o_tvalid,
    input  logic                                  i_tready
);

    // data-page beats toward the joiner
    logic                                  join_wvalid;
    logic                                  join_wready;
    logic [gem_stream_pkg::DATA_WIDTH-1:0] join_wdata;

    // events for the tlast decision
    logic beat_valid;
    logic beat_at_base;
    logic dma_complete;

    // decided tlast flags, one per data beat
    logic flag_valid;
    logic flag_last;

    assign o_bresp = gem_stream_pkg::RESP_OKAY;

    axi_write_ctrl i_axi_write_ctrl (
        .clk           (clk),
        .reset         (reset),
        .i_awid        (i_awid),
        .i_awaddr      (i_awaddr),
        .i_awlen       (i_awlen),
        .i_awvalid     (i_awvalid),
        .i_wdata       (i_wdata),
        .i_wlast       (i_wlast),
        .i_wvalid      (i_wvalid),
        .i_bready      (i_bready),
        .i_join_wready (join_wready),
        .o_awready     (o_awready),
        .o_wready      (o_wready),
        .o_bid         (o_bid),
        .o_bvalid      (o_bvalid),
        .o_join_wvalid (join_wvalid),
        .o_join_wdata  (join_wdata),
        .o_beat_valid  (beat_valid),
        .o_beat_at_base(beat_at_base),
        .o_dma_complete(dma_complete)
    );

    beat_last_tracker i_beat_last_tracker (
        .clk           (clk),
        .reset         (reset),
        .i_beat_valid  (beat_valid),
        .i_beat_at_base(beat_at_base),
        .i_dma_complete(dma_complete),
        .o_flag_valid  (flag_valid),
        .o_flag_last   (flag_last)
    );

    beat_join i_beat_join (
        .clk         (clk),
        .reset       (reset),
        .i_wvalid    (join_wvalid),
        .i_wdata     (join_wdata),
        .i_flag_valid(flag_valid),
        .i_flag_last (flag_last),
        .i_tready    (i_tready),
        .o_wready    (join_wready),
        .o_tdata     (o_tdata),
        .o_tlast     (o_tlast),
        .o_tvalid    (o_tvalid)
    );

endmodule

// ==== verif/tb_gem_write_to_stream.sv ====
`timescale 1ns/1ps

module tb_gem_write_to_stream;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic [gem_stream_pkg::ID_WIDTH-1:0] i_awid = '0;
    logic [gem_stream_pkg::ID_WIDTH-1:0] o_bid;
    logic [gem_stream_pkg::ADDR_WIDTH-1:0] i_awaddr = '0;
    logic [7:0] i_awlen = '0;
    logic i_awvalid = 1'b0;
    logic o_awready;
    logic i_wlast = 1'b0;
    logic i_wvalid = 1'b0;
    logic o_wready;
    logic [gem_stream_pkg::DATA_WIDTH-1:0] i_wdata = '0;
    logic [gem_stream_pkg::DATA_WIDTH-1:0] o_tdata;
    logic [1:0] o_bresp;
    logic o_bvalid;
    logic i_bready = 1'b0;
    logic o_tlast;
    logic o_tvalid;
    logic i_tready = 1'b1;

    integer seed = 32'h24e79e7d;
    int errors = 0;
    logic pending = 1'b0;
    logic bp_done = 1'b0;
    logic [gem_stream_pkg::DATA_WIDTH-1:0] exp_data[$];
    logic [gem_stream_pkg::DATA_WIDTH-1:0] got_data[$];
    logic exp_last[$];
    logic got_last[$];

    gem_write_to_stream i_gem_write_to_stream (.*);

    always #4 clk = ~clk;

    // inputs move just after the rising edge, so the falling edge sees a settled handshake
    always @(negedge clk) begin
        if (o_tvalid && i_tready) begin
            got_data.push_back(o_tdata);
            got_last.push_back(o_tlast);
        end
    end

    // a data beat decides the undecided one before it
    function automatic void record_beat(input logic [31:0] data, input logic at_base);
        if (pending && at_base)
            exp_last[exp_last.size()-1] = 1'b1;
        exp_data.push_back(data);
        exp_last.push_back(1'b0);
        pending = 1'b1;
    endfunction

    function automatic void close_packet();
        if (pending)
            exp_last[exp_last.size()-1] = 1'b1;
        pending = 1'b0;
    endfunction

    // after reset only AW may be ready, nothing else is valid
    task automatic check_reset_outputs();
        if (o_awready !== 1'b1 || o_wready !== 1'b0 || o_bvalid !== 1'b0
            || o_tvalid !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: after reset awready %b wready %b bvalid %b tvalid %b",
                     $time, o_awready, o_wready, o_bvalid, o_tvalid);
        end
    endtask

    task automatic send_burst(input logic [12:0] addr, input logic [3:0] id, input int beats,
                              input logic rand_data, input logic [31:0] word);
        logic [11:0] offset;
        logic [31:0] data;
        int i;
        offset = addr[11:0];
        i_awaddr = addr;
        i_awid = id;
        i_awlen = 8'(beats - 1);
        i_awvalid = 1'b1;
        do @(negedge clk); while (!o_awready);
        @(posedge clk);
        #1 i_awvalid = 1'b0;
        for (i = 0; i < beats; i++) begin
            data = rand_data ? $random(seed) : word;
            i_wdata = data;
            i_wlast = (i == beats - 1);
            i_wvalid = 1'b1;
            do @(negedge clk); while (!o_wready);
            @(posedge clk);
            #1;
            if (addr[gem_stream_pkg::PAGE_BIT] == gem_stream_pkg::DATA_PAGE)
                record_beat(data, offset == gem_stream_pkg::DATA_BASE_ADDR);
            else if (offset == gem_stream_pkg::DMA_COMPLETE_REG
                     && (data & gem_stream_pkg::DMA_COMPLETE_MASK) != 0)
                close_packet();
            offset = offset + 12'd4;
        end
        i_wvalid = 1'b0;
        i_wlast = 1'b0;
        i_bready = 1'b1;
        do @(negedge clk); while (!o_bvalid);
        if (o_bid !== id) begin
            errors++;
            $display("mismatch at %0t: bid %h, expected %h", $time, o_bid, id);
        end
        if (o_bresp !== 2'b00) begin
            errors++;
            $display("mismatch at %0t: bresp %b, expected OKAY", $time, o_bresp);
        end
        @(posedge clk);
        #1 i_bready = 1'b0;
    endtask

    task automatic write_burst(input logic [12:0] addr, input logic [3:0] id, input int beats);
        send_burst(addr, id, beats, 1'b1, 32'h0);
    endtask

    task automatic dma_done();
        send_burst(13'h1000, 4'hf, 1, 1'b0, 32'h1);
    endtask

    task automatic expect_stream(input int count);
        logic [31:0] d;
        logic l;
        while (got_data.size() < count) @(negedge clk);
        repeat (count) begin
            d = got_data.pop_front();
            l = got_last.pop_front();
            if (exp_data.size() == 0) begin
                errors++;
                $display("stream sent a beat that was never written, data %h", d);
            end else if (d !== exp_data[0] || l !== exp_last[0]) begin
                errors++;
                $display("mismatch at %0t: tdata %h tlast %b, expected %h %b", $time, d, l,
                         exp_data[0], exp_last[0]);
            end
            if (exp_data.size() != 0) begin
                void'(exp_data.pop_front());
                void'(exp_last.pop_front());
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic single_packet();
        write_burst(13'h000, 4'h1, 6);
        dma_done();
        expect_stream(6);
    endtask

    task automatic back_to_back_packets();
        write_burst(13'h000, 4'h2, 4);
        write_burst(13'h000, 4'h3, 3);
        dma_done();
        expect_stream(7);
    endtask

    task automatic packet_across_bursts();
        write_burst(13'h000, 4'h4, 3);
        write_burst(13'h00c, 4'h5, 2);
        dma_done();
        expect_stream(5);
    endtask

    // tready flips at random while the writer is stalled by the full FIFOs
    task automatic stream_backpressure();
        bp_done = 1'b0;
        fork
            begin
                write_burst(13'h000, 4'h6, 16);
                dma_done();
                bp_done = 1'b1;
            end
            while (!bp_done) begin
                @(posedge clk);
                #1 i_tready = 1'($random(seed));
            end
        join
        i_tready = 1'b1;
        expect_stream(16);
    endtask

    task automatic control_writes();
        write_burst(13'h000, 4'h7, 2);
        send_burst(13'h1000, 4'h8, 1, 1'b0, 32'h0);
        send_burst(13'h1004, 4'h9, 1, 1'b0, 32'h1);
        repeat (6) @(posedge clk);
        #1;
        if (got_data.size() != 1) begin
            errors++;
            $display("mismatch at %0t: %0d stream beats after control writes, expected 1",
                     $time, got_data.size());
        end
        dma_done();
        expect_stream(2);
    endtask

    initial begin
        #20000;
        $display("watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

    initial begin
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        check_reset_outputs();
        single_packet();
        back_to_back_packets();
        packet_across_bursts();
        stream_backpressure();
        control_writes();
        repeat (10) @(posedge clk);
        if (got_data.size() != 0 || exp_data.size() != 0) begin
            errors++;
            $display("%0d unexpected and %0d missing stream beats", got_data.size(),
                     exp_data.size());
        end
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/gem_stream_pkg.sv
logic/axi_write_ctrl.sv
logic/beat_last_tracker.sv
logic/beat_join.sv
logic/gem_write_to_stream.sv
verif/tb_gem_write_to_stream.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module tb_gem_write_to_stream \
    -f filelist.f -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Done: errors found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
